// ==== source/eth_pkg.sv ====
package eth_pkg;

    ////////////////////
    // cfg bus map

    localparam int CFG_ADDR_W = 5;

    localparam logic [CFG_ADDR_W-1:0] REG_CTRL   = 5'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_TX_LEN = 5'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_STATUS = 5'd2; // read clears rx overflow
    localparam logic [CFG_ADDR_W-1:0] REG_RX_LEN = 5'd3;

    localparam int CTRL_EN_TX_BIT     = 0;
    localparam int CTRL_EN_RX_BIT     = 1;
    localparam int CTRL_RX_IRQ_EN_BIT = 2;

    localparam int STATUS_TX_BUSY_BIT = 0;
    localparam int STATUS_RX_OVF_BIT  = 1;

    ////////////////////
    // frame constants

    localparam int LEN_W = 16; // byte counts, tx and rx

    localparam int         PREAMBLE_BYTES = 7;
    localparam logic [7:0] PREAMBLE_VAL   = 8'h55; // dibits 01 01 01 01
    localparam logic [7:0] SFD_BYTE       = 8'hD5; // closing dibit is 11

    localparam int RX_FIFO_DEPTH = 8; // words
    localparam int RX_FIFO_PTR_W = $clog2(RX_FIFO_DEPTH);

    ////////////////////
    // state machines

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HUNT,  // waiting for the 11 dibit
        RX_DATA
    } rx_state_e;

endpackage

// ==== source/eth_regs.sv ====
module eth_regs
    import eth_pkg::*;
(
    input  logic                  sys_clk_i,
    input  logic                  reset_i,
    input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [31:0]           cfg_data_i,
    input  logic                  cfg_valid_i,
    input  logic                  cfg_rwn_i,
    output logic                  cfg_ready_o,
    output logic [31:0]           cfg_data_o,
    input  logic                  tx_busy_i,
    input  logic [LEN_W-1:0]      rx_len_i,
    input  logic                  rx_len_valid_i,
    input  logic                  rx_ovf_i,
    output logic                  en_tx_o,
    output logic                  en_rx_o,
    output logic                  rx_irq_en_o,
    output logic [LEN_W-1:0]      tx_len_o,
    output logic                  tx_start_o,
    output logic                  rx_ovf_clr_o
);

    logic             cfg_wr;
    logic             cfg_rd;
    logic             tx_len_wr;
    logic [LEN_W-1:0] rx_len_q;  // length of the last received frame
    logic [31:0]      rd_data;

    assign cfg_wr    = cfg_valid_i & ~cfg_rwn_i;
    assign cfg_rd    = cfg_valid_i & cfg_rwn_i;
    assign tx_len_wr = cfg_wr && (cfg_addr_i == REG_TX_LEN) && !tx_busy_i; // dropped while busy

    // fifo samples the clear at the same edge the status word is captured
    assign rx_ovf_clr_o = cfg_rd && (cfg_addr_i == REG_STATUS);

    ////////////////////
    // read mux

    always_comb begin
        rd_data = '0;
        case (cfg_addr_i)
            REG_CTRL: begin
                rd_data[CTRL_EN_TX_BIT]     = en_tx_o;
                rd_data[CTRL_EN_RX_BIT]     = en_rx_o;
                rd_data[CTRL_RX_IRQ_EN_BIT] = rx_irq_en_o;
            end
            REG_TX_LEN: rd_data[LEN_W-1:0] = tx_len_o;
            REG_STATUS: begin
                rd_data[STATUS_TX_BUSY_BIT] = tx_busy_i;
                rd_data[STATUS_RX_OVF_BIT]  = rx_ovf_i;
            end
            REG_RX_LEN: rd_data[LEN_W-1:0] = rx_len_q;
            default: ;                            // unmapped reads as zero
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            cfg_ready_o <= 1'b0;
            en_tx_o     <= 1'b0;
            en_rx_o     <= 1'b0;
            rx_irq_en_o <= 1'b0;
            tx_start_o  <= 1'b0;
        end else begin
            cfg_ready_o <= cfg_valid_i;           // every access answers next cycle
            tx_start_o  <= tx_len_wr & en_tx_o;   // single cycle kick to the fetcher
            if (cfg_wr && (cfg_addr_i == REG_CTRL)) begin
                en_tx_o     <= cfg_data_i[CTRL_EN_TX_BIT];
                en_rx_o     <= cfg_data_i[CTRL_EN_RX_BIT];
                rx_irq_en_o <= cfg_data_i[CTRL_RX_IRQ_EN_BIT];
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (cfg_rd)         cfg_data_o <= rd_data;
        if (tx_len_wr)      tx_len_o   <= cfg_data_i[LEN_W-1:0];
        if (rx_len_valid_i) rx_len_q   <= rx_len_i;
    end

    ////////////////////
    // checks

    a_ready_follows_valid : assert property (
        @(posedge sys_clk_i) disable iff (reset_i)
        $rose(cfg_ready_o) |-> $past(cfg_valid_i)
    );

endmodule

// ==== source/eth_tx_fetch.sv ====
module eth_tx_fetch
    import eth_pkg::*;
(
    input  logic             sys_clk_i,
    input  logic             reset_i,
    input  logic             tx_start_i,
    input  logic [LEN_W-1:0] tx_len_i,
    input  logic [31:0]      data_tx_i,
    input  logic             data_tx_valid_i,
    input  logic             tx_byte_ready_i,
    output logic             data_tx_ready_o,
    output logic [7:0]       tx_byte_o,
    output logic             tx_byte_valid_o,
    output logic             tx_byte_last_o
);

    logic [LEN_W-1:0] remain_q;   // bytes still to hand over
    logic [31:0]      word_q;     // shifts right, current byte at the bottom
    logic [1:0]       byte_idx_q;
    logic             word_vld_q;
    logic             word_take;
    logic             byte_take;

    assign data_tx_ready_o = (remain_q != '0) && !word_vld_q; // refill only when empty
    assign word_take       = data_tx_ready_o && data_tx_valid_i;
    assign byte_take       = tx_byte_valid_o && tx_byte_ready_i;

    assign tx_byte_valid_o = word_vld_q;
    assign tx_byte_o       = word_q[7:0];
    assign tx_byte_last_o  = (remain_q == LEN_W'(1));

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            remain_q   <= '0;
            byte_idx_q <= '0;
            word_vld_q <= 1'b0;
        end else begin
            if (tx_start_i) begin
                remain_q <= tx_len_i;
            end else if (byte_take) begin
                remain_q <= remain_q - LEN_W'(1);
            end

            if (word_take) begin
                word_vld_q <= 1'b1;
                byte_idx_q <= '0;
            end else if (byte_take) begin
                byte_idx_q <= byte_idx_q + 2'd1;
                // word used up, or frame done and the upper bytes are dropped
                if (byte_idx_q == 2'd3 || tx_byte_last_o)
                    word_vld_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (word_take)
            word_q <= data_tx_i;
        else if (byte_take)
            word_q <= word_q >> 8;                // low byte first
    end

endmodule

// ==== source/eth_rmii_tx.sv ====
module eth_rmii_tx
    import eth_pkg::*;
(
    input  logic       sys_clk_i,
    input  logic       reset_i,
    input  logic [7:0] tx_byte_i,
    input  logic       tx_byte_valid_i,
    input  logic       tx_byte_last_i,
    output logic       tx_byte_ready_o,
    output logic       tx_busy_o,
    output logic [1:0] phy_txd,
    output logic       phy_tx_en
);

    tx_state_e  state_q;
    logic [7:0] shift_q;    // byte on the wire, dibit 0 at the bottom
    logic [1:0] dibit_q;
    logic [2:0] pre_cnt_q;
    logic       last_q;     // byte now on the wire closes the frame
    logic       byte_end;
    logic       pre_done;

    assign byte_end = (dibit_q == 2'd3);
    assign pre_done = (pre_cnt_q == 3'(PREAMBLE_BYTES - 1));

    // next byte is pulled during the final dibit of the current one
    assign tx_byte_ready_o = byte_end &&
                             ((state_q == TX_SFD) || (state_q == TX_DATA && !last_q));
    assign tx_busy_o = (state_q != TX_IDLE);
    assign phy_txd   = shift_q[1:0];

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            state_q   <= TX_IDLE;
            phy_tx_en <= 1'b0;
            dibit_q   <= '0;
            pre_cnt_q <= '0;
            last_q    <= 1'b0;
        end else begin
            dibit_q <= (state_q == TX_IDLE) ? 2'd0 : dibit_q + 2'd1;
            case (state_q)
                TX_IDLE: begin
                    pre_cnt_q <= '0;
                    if (tx_byte_valid_i) begin    // first byte waiting, start the frame
                        state_q   <= TX_PREAMBLE;
                        phy_tx_en <= 1'b1;
                    end
                end
                TX_PREAMBLE: begin
                    if (byte_end) begin
                        pre_cnt_q <= pre_cnt_q + 3'd1;
                        if (pre_done) state_q <= TX_SFD;
                    end
                end
                TX_SFD: begin
                    if (byte_end) begin
                        state_q <= TX_DATA;
                        last_q  <= tx_byte_last_i;
                    end
                end
                TX_DATA: begin
                    if (byte_end) begin
                        if (last_q) begin
                            state_q   <= TX_IDLE;
                            phy_tx_en <= 1'b0;
                        end else begin
                            last_q <= tx_byte_last_i;
                        end
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (state_q == TX_IDLE)
            shift_q <= PREAMBLE_VAL;              // preload first preamble byte
        else if (!byte_end)
            shift_q <= shift_q >> 2;
        else if (state_q == TX_PREAMBLE)
            shift_q <= pre_done ? SFD_BYTE : PREAMBLE_VAL;
        else
            shift_q <= tx_byte_i;
    end

    a_no_tx_en_in_idle : assert property (
        @(posedge sys_clk_i) disable iff (reset_i)
        phy_tx_en |-> (state_q != TX_IDLE)
    );

endmodule

// ==== source/eth_rmii_rx.sv ====
module eth_rmii_rx
    import eth_pkg::*;
(
    input  logic       sys_clk_i,
    input  logic       reset_i,
    input  logic       en_rx_i,
    input  logic [1:0] phy_rxd,
    input  logic       phy_crs_dv,
    output logic [7:0] rx_byte_o,
    output logic       rx_byte_valid_o,
    output logic       rx_frame_end_o
);

    rx_state_e  state_q;
    logic [7:0] shift_q;    // dibits enter at the top, low pair first
    logic [1:0] dibit_q;

    // after the fourth shift the register holds the whole byte
    assign rx_byte_o = shift_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            state_q         <= RX_IDLE;
            dibit_q         <= '0;
            rx_byte_valid_o <= 1'b0;
            rx_frame_end_o  <= 1'b0;
        end else begin
            rx_byte_valid_o <= 1'b0;
            rx_frame_end_o  <= 1'b0;
            if (!en_rx_i) begin
                state_q <= RX_IDLE;               // wire ignored entirely
            end else begin
                case (state_q)
                    RX_IDLE: begin
                        if (phy_crs_dv) state_q <= RX_HUNT;
                    end
                    RX_HUNT: begin
                        dibit_q <= '0;
                        if (!phy_crs_dv)
                            state_q <= RX_IDLE;   // carrier lost before sfd
                        else if (phy_rxd == 2'b11)
                            state_q <= RX_DATA;
                    end
                    RX_DATA: begin
                        if (!phy_crs_dv) begin
                            state_q        <= RX_IDLE;
                            rx_frame_end_o <= 1'b1;
                        end else begin
                            dibit_q         <= dibit_q + 2'd1;
                            rx_byte_valid_o <= (dibit_q == 2'd3);
                        end
                    end
                    default: state_q <= RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (state_q == RX_DATA)
            shift_q <= {phy_rxd, shift_q[7:2]};
    end

endmodule

// ==== source/eth_rx_pack.sv ====
module eth_rx_pack
    import eth_pkg::*;
(
    input  logic             sys_clk_i,
    input  logic             reset_i,
    input  logic [7:0]       rx_byte_i,
    input  logic             rx_byte_valid_i,
    input  logic             rx_frame_end_i,
    input  logic             rx_irq_en_i,
    output logic [31:0]      rx_word_o,
    output logic [1:0]       rx_word_bytes_o,
    output logic             rx_word_push_o,
    output logic [LEN_W-1:0] rx_len_o,
    output logic             rx_len_valid_o,
    output logic             eth_rx_event_o
);

    logic [31:0]      word_q;
    logic [1:0]       fill_q;  // bytes already in word_q
    logic [LEN_W-1:0] len_q;   // running byte count of the frame

    // word_q stays put for a few cycles after a push, bytes are 4 clocks apart
    assign rx_word_o = word_q;

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            fill_q         <= '0;
            len_q          <= '0;
            rx_word_push_o <= 1'b0;
            rx_len_valid_o <= 1'b0;
            eth_rx_event_o <= 1'b0;
        end else begin
            rx_word_push_o <= 1'b0;
            rx_len_valid_o <= 1'b0;
            eth_rx_event_o <= 1'b0;
            if (rx_byte_valid_i) begin
                fill_q         <= fill_q + 2'd1;
                len_q          <= len_q + LEN_W'(1);
                rx_word_push_o <= (fill_q == 2'd3);   // full word
            end else if (rx_frame_end_i) begin
                fill_q         <= '0;
                len_q          <= '0;
                rx_word_push_o <= (fill_q != 2'd0);   // flush partial word
                rx_len_valid_o <= 1'b1;
                eth_rx_event_o <= rx_irq_en_i;
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (rx_byte_valid_i) begin
            word_q[8*fill_q +: 8] <= rx_byte_i;
            rx_word_bytes_o       <= 2'd3;
        end else if (rx_frame_end_i) begin
            rx_word_bytes_o <= fill_q - 2'd1;       // count minus one
            rx_len_o        <= len_q;
        end
    end

endmodule

// ==== source/eth_rx_fifo.sv ====
module eth_rx_fifo
    import eth_pkg::*;
(
    input  logic        sys_clk_i,
    input  logic        reset_i,
    input  logic [31:0] rx_word_i,
    input  logic [1:0]  rx_word_bytes_i,
    input  logic        rx_word_push_i,
    input  logic        data_rx_ready_i,
    input  logic        rx_ovf_clr_i,
    output logic [31:0] data_rx_o,
    output logic [1:0]  data_rx_bytes_o,
    output logic        data_rx_valid_o,
    output logic        rx_ovf_o
);

    logic [33:0]              mem_q [RX_FIFO_DEPTH]; // {bytes, word}
    logic [RX_FIFO_PTR_W-1:0] wr_ptr_q;
    logic [RX_FIFO_PTR_W-1:0] rd_ptr_q;
    logic [RX_FIFO_PTR_W:0]   count_q;
    logic                     full;
    logic                     push_ok;
    logic                     pop;

    assign full    = (count_q == (RX_FIFO_PTR_W + 1)'(RX_FIFO_DEPTH));
    assign push_ok = rx_word_push_i && !full;          // push into full fifo is lost
    assign pop     = data_rx_valid_o && data_rx_ready_i;

    assign data_rx_valid_o               = (count_q != '0);
    assign {data_rx_bytes_o, data_rx_o}  = mem_q[rd_ptr_q];

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            rx_ovf_o <= 1'b0;
        end else begin
            if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
            if (pop)     rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
            if (rx_word_push_i && full)
                rx_ovf_o <= 1'b1;                      // sticky, set wins over clear
            else if (rx_ovf_clr_i)
                rx_ovf_o <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (push_ok) mem_q[wr_ptr_q] <= {rx_word_bytes_i, rx_word_i};
    end

    a_count_in_range : assert property (
        @(posedge sys_clk_i) disable iff (reset_i)
        count_q <= (RX_FIFO_PTR_W + 1)'(RX_FIFO_DEPTH)
    );

endmodule

// ==== source/eth_mac_top.sv ====
module eth_mac_top
    import eth_pkg::*;
(
    input  logic                  sys_clk_i,
    input  logic                  reset_i,
    input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [31:0]           cfg_data_i,
    input  logic                  cfg_valid_i,
    input  logic                  cfg_rwn_i,
    output logic                  cfg_ready_o,
    output logic [31:0]           cfg_data_o,
    input  logic [31:0]           data_tx_i,
    input  logic                  data_tx_valid_i,
    output logic                  data_tx_ready_o,
    output logic [31:0]           data_rx_o,
    output logic [1:0]            data_rx_bytes_o,
    output logic                  data_rx_valid_o,
    input  logic                  data_rx_ready_i,
    output logic [1:0]            phy_txd,
    output logic                  phy_tx_en,
    input  logic [1:0]            phy_rxd,
    input  logic                  phy_crs_dv,
    output logic                  eth_rx_event_o
);

    logic             en_tx;
    logic             en_rx;
    logic             rx_irq_en;
    logic [LEN_W-1:0] tx_len;
    logic             tx_start;
    logic             tx_busy;
    logic [7:0]       tx_byte;
    logic             tx_byte_valid;
    logic             tx_byte_last;
    logic             tx_byte_ready;
    logic [7:0]       rx_byte;
    logic             rx_byte_valid;
    logic             rx_frame_end;
    logic [31:0]      rx_word;
    logic [1:0]       rx_word_bytes;
    logic             rx_word_push;
    logic [LEN_W-1:0] rx_len;
    logic             rx_len_valid;
    logic             rx_ovf;
    logic             rx_ovf_clr;

    eth_regs u_regs (
        .sys_clk_i      (sys_clk_i),
        .reset_i        (reset_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_rwn_i      (cfg_rwn_i),
        .cfg_ready_o    (cfg_ready_o),
        .cfg_data_o     (cfg_data_o),
        .tx_busy_i      (tx_busy),
        .rx_len_i       (rx_len),
        .rx_len_valid_i (rx_len_valid),
        .rx_ovf_i       (rx_ovf),
        .en_tx_o        (en_tx),
        .en_rx_o        (en_rx),
        .rx_irq_en_o    (rx_irq_en),
        .tx_len_o       (tx_len),
        .tx_start_o     (tx_start),
        .rx_ovf_clr_o   (rx_ovf_clr)
    );

    ////////////////////
    // transmit path

    eth_tx_fetch u_tx_fetch (
        .sys_clk_i       (sys_clk_i),
        .reset_i         (reset_i),
        .tx_start_i      (tx_start),
        .tx_len_i        (tx_len),
        .data_tx_i       (data_tx_i),
        .data_tx_valid_i (data_tx_valid_i),
        .tx_byte_ready_i (tx_byte_ready),
        .data_tx_ready_o (data_tx_ready_o),
        .tx_byte_o       (tx_byte),
        .tx_byte_valid_o (tx_byte_valid),
        .tx_byte_last_o  (tx_byte_last)
    );

    eth_rmii_tx u_rmii_tx (
        .sys_clk_i       (sys_clk_i),
        .reset_i         (reset_i),
        .tx_byte_i       (tx_byte),
        .tx_byte_valid_i (tx_byte_valid),
        .tx_byte_last_i  (tx_byte_last),
        .tx_byte_ready_o (tx_byte_ready),
        .tx_busy_o       (tx_busy),
        .phy_txd         (phy_txd),
        .phy_tx_en       (phy_tx_en)
    );

    ////////////////////
    // receive path

    eth_rmii_rx u_rmii_rx (
        .sys_clk_i       (sys_clk_i),
        .reset_i         (reset_i),
        .en_rx_i         (en_rx),
        .phy_rxd         (phy_rxd),
        .phy_crs_dv      (phy_crs_dv),
        .rx_byte_o       (rx_byte),
        .rx_byte_valid_o (rx_byte_valid),
        .rx_frame_end_o  (rx_frame_end)
    );

    eth_rx_pack u_rx_pack (
        .sys_clk_i       (sys_clk_i),
        .reset_i         (reset_i),
        .rx_byte_i       (rx_byte),
        .rx_byte_valid_i (rx_byte_valid),
        .rx_frame_end_i  (rx_frame_end),
        .rx_irq_en_i     (rx_irq_en),
        .rx_word_o       (rx_word),
        .rx_word_bytes_o (rx_word_bytes),
        .rx_word_push_o  (rx_word_push),
        .rx_len_o        (rx_len),
        .rx_len_valid_o  (rx_len_valid),
        .eth_rx_event_o  (eth_rx_event_o)
    );

    eth_rx_fifo u_rx_fifo (
        .sys_clk_i       (sys_clk_i),
        .reset_i         (reset_i),
        .rx_word_i       (rx_word),
        .rx_word_bytes_i (rx_word_bytes),
        .rx_word_push_i  (rx_word_push),
        .data_rx_ready_i (data_rx_ready_i),
        .rx_ovf_clr_i    (rx_ovf_clr),
        .data_rx_o       (data_rx_o),
        .data_rx_bytes_o (data_rx_bytes_o),
        .data_rx_valid_o (data_rx_valid_o),
        .rx_ovf_o        (rx_ovf)
    );

endmodule

// ==== tb/tb_eth_mac.sv ====
module tb_eth_mac
    import eth_pkg::*;
();

    localparam int          WAIT_LIMIT = 200;  // cycles allowed per wait
    localparam int          NUM_FRAMES = 4;
    localparam logic [31:0] CTRL_TX    = 32'h1 << CTRL_EN_TX_BIT;
    localparam logic [31:0] CTRL_RX    = 32'h1 << CTRL_EN_RX_BIT;
    localparam logic [31:0] CTRL_IRQ   = 32'h1 << CTRL_RX_IRQ_EN_BIT;

    logic                  sys_clk;
    logic                  reset;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [31:0]           cfg_wdata;
    logic                  cfg_valid;
    logic                  cfg_rwn;
    logic                  cfg_ready;
    logic [31:0]           cfg_rdata;
    logic [31:0]           data_tx       = '0;   // owned by the word feeder
    logic                  data_tx_valid = 1'b0;
    logic                  data_tx_ready;
    logic [31:0]           data_rx;
    logic [1:0]            data_rx_bytes;
    logic                  data_rx_valid;
    logic                  data_rx_ready;
    logic [1:0]            phy_txd;
    logic                  phy_tx_en;
    logic                  eth_rx_event;

    // frame table with words filled at start of run
    int          frame_len  [NUM_FRAMES];
    logic [31:0] frame_word [NUM_FRAMES][3];

    logic [31:0] tx_stream [$];  // every word offered on the tx channel
    logic [31:0] rx_words  [$];  // every word taken from the rx channel
    logic [1:0]  rx_bytes  [$];
    int          feed_ptr       = 0;
    int          next_ptr;
    int          event_cnt      = 0;
    int          tx_en_run      = 0;
    int          last_tx_en_run = 0;

    eth_mac_top DUT (
        .sys_clk_i       (sys_clk),
        .reset_i         (reset),
        .cfg_addr_i      (cfg_addr),
        .cfg_data_i      (cfg_wdata),
        .cfg_valid_i     (cfg_valid),
        .cfg_rwn_i       (cfg_rwn),
        .cfg_ready_o     (cfg_ready),
        .cfg_data_o      (cfg_rdata),
        .data_tx_i       (data_tx),
        .data_tx_valid_i (data_tx_valid),
        .data_tx_ready_o (data_tx_ready),
        .data_rx_o       (data_rx),
        .data_rx_bytes_o (data_rx_bytes),
        .data_rx_valid_o (data_rx_valid),
        .data_rx_ready_i (data_rx_ready),
        .phy_txd         (phy_txd),
        .phy_tx_en       (phy_tx_en),
        .phy_rxd         (phy_txd),      // rmii loopback
        .phy_crs_dv      (phy_tx_en),
        .eth_rx_event_o  (eth_rx_event)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    ////////////////////
    // tx feeder and monitors

    always @(posedge sys_clk) begin
        if (reset) begin
            feed_ptr      <= 0;
            data_tx_valid <= 1'b0;
        end else begin
            next_ptr = feed_ptr;
            if (data_tx_valid && data_tx_ready)
                next_ptr = feed_ptr + 1;              // word taken at this edge
            feed_ptr      <= next_ptr;
            data_tx_valid <= (next_ptr < tx_stream.size());
            data_tx       <= (next_ptr < tx_stream.size()) ? tx_stream[next_ptr] : 32'h0;
        end
    end

    // monitors for rx words, events and tx_en bursts
    always @(negedge sys_clk) begin
        if (!reset && data_rx_valid && data_rx_ready) begin
            rx_words.push_back(data_rx);
            rx_bytes.push_back(data_rx_bytes);
        end
        if (!reset && eth_rx_event)
            event_cnt <= event_cnt + 1;
        if (phy_tx_en) begin
            tx_en_run <= tx_en_run + 1;
        end else if (tx_en_run != 0) begin
            last_tx_en_run <= tx_en_run;              // length of the burst just ended
            tx_en_run      <= 0;
        end
    end

    ////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "wait limit reached");
    endtask

    function automatic int word_count(input int nbytes);
        return (nbytes + 3) / 4;
    endfunction

    function automatic logic [31:0] byte_mask(input int nbytes);
        return (nbytes >= 4) ? 32'hFFFF_FFFF : (32'h1 << (8 * nbytes)) - 32'h1;
    endfunction

    // one cfg access with ready due exactly one cycle after valid
    task automatic access_reg(input logic rwn, input logic [CFG_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        cfg_valid <= 1'b1;
        cfg_rwn   <= rwn;
        cfg_addr  <= addr;
        cfg_wdata <= wdata;
        @(posedge sys_clk);                           // dut samples the access here
        cfg_valid <= 1'b0;
        check_value("cfg_ready_o", cfg_ready, 1'b0);
        @(posedge sys_clk);
        check_value("cfg_ready_o", cfg_ready, 1'b1);
        rdata = cfg_rdata;
    endtask

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        access_reg(1'b0, addr, wdata, unused);
    endtask

    task automatic read_reg(input logic [CFG_ADDR_W-1:0] addr, output logic [31:0] rdata);
        access_reg(1'b1, addr, 32'h0, rdata);
    endtask

    task automatic collect_rx(input int target);
        int n;
        n = 0;
        while (rx_words.size() < target) begin
            if (n == WAIT_LIMIT) report_timeout("words on data_rx_o");
            @(posedge sys_clk);
            n++;
        end
    endtask

    // queue the words, start the frame, follow it on the wire
    task automatic send_frame(input int idx, input logic with_status);
        logic [31:0] rd;
        int          n;
        for (int k = 0; k < word_count(frame_len[idx]); k++)
            tx_stream.push_back(frame_word[idx][k]);
        write_reg(REG_TX_LEN, frame_len[idx]);
        n = 0;
        while (!phy_tx_en) begin
            if (n == WAIT_LIMIT) report_timeout("phy_tx_en to rise");
            @(posedge sys_clk);
            n++;
        end
        if (with_status) begin
            read_reg(REG_STATUS, rd);
            check_value("cfg_data_o tx busy", rd[STATUS_TX_BUSY_BIT], 1'b1);
        end
        n = 0;
        while (phy_tx_en) begin
            if (n == WAIT_LIMIT) report_timeout("phy_tx_en to fall");
            @(posedge sys_clk);
            n++;
        end
        repeat (4) @(posedge sys_clk);                // frame end, flush, fifo write
        check_value("phy_tx_en high cycles", last_tx_en_run, 4 * (8 + frame_len[idx]));
        if (with_status) begin
            read_reg(REG_STATUS, rd);
            check_value("cfg_data_o tx busy", rd[STATUS_TX_BUSY_BIT], 1'b0);
        end
    endtask

    task automatic verify_rx_frame(input int idx, input int base);
        int          nb;
        logic [31:0] mask;
        check_value("rx word count", rx_words.size() - base, word_count(frame_len[idx]));
        for (int k = 0; k < word_count(frame_len[idx]); k++) begin
            nb = frame_len[idx] - 4 * k;
            if (nb > 4)
                nb = 4;
            mask = byte_mask(nb);                     // bytes past the frame are don't care
            check_value("data_rx_o", rx_words[base + k] & mask, frame_word[idx][k] & mask);
            check_value("data_rx_bytes_o", rx_bytes[base + k], nb - 1);
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        int unsigned seed_val;
        logic [31:0] rd;
        int          base;
        int          ev;
        int          n;
        reset         = 1'b1;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        cfg_valid     = 1'b0;
        cfg_rwn       = 1'b0;
        data_rx_ready = 1'b1;
        seed_val      = $urandom(32'h7b66_b3b7);
        frame_len[0]  = 4;
        frame_len[1]  = 7;
        frame_len[2]  = 12;
        frame_len[3]  = 1;
        for (int i = 0; i < NUM_FRAMES; i++)
            for (int k = 0; k < 3; k++)
                frame_word[i][k] = $urandom;
        repeat (8) @(posedge sys_clk);
        reset <= 1'b0;

        // control outputs idle out of reset
        check_value("cfg_ready_o", cfg_ready, 1'b0);
        check_value("data_tx_ready_o", data_tx_ready, 1'b0);
        check_value("data_rx_valid_o", data_rx_valid, 1'b0);
        check_value("phy_tx_en", phy_tx_en, 1'b0);
        check_value("eth_rx_event_o", eth_rx_event, 1'b0);

        write_reg(REG_CTRL, CTRL_TX | CTRL_RX | CTRL_IRQ);
        read_reg(REG_CTRL, rd);
        check_value("cfg_data_o ctrl", rd, CTRL_TX | CTRL_RX | CTRL_IRQ);

        // whole table with the rx interrupt on
        for (int i = 0; i < NUM_FRAMES; i++) begin
            base = rx_words.size();
            ev   = event_cnt;
            send_frame(i, 1'b1);
            collect_rx(base + word_count(frame_len[i]));
            verify_rx_frame(i, base);
            check_value("eth_rx_event_o count", event_cnt - ev, 1);
            read_reg(REG_RX_LEN, rd);
            check_value("cfg_data_o rx len", rd, frame_len[i]);
        end

        // interrupt masked but data still arrives
        write_reg(REG_CTRL, CTRL_TX | CTRL_RX);
        base = rx_words.size();
        ev   = event_cnt;
        send_frame(1, 1'b1);
        collect_rx(base + word_count(frame_len[1]));
        verify_rx_frame(1, base);
        check_value("eth_rx_event_o count", event_cnt - ev, 0);

        // receiver off
        write_reg(REG_CTRL, CTRL_TX);
        read_reg(REG_CTRL, rd);
        check_value("cfg_data_o ctrl", rd, CTRL_TX);
        base = rx_words.size();
        send_frame(3, 1'b1);
        check_value("data_rx_valid_o", data_rx_valid, 1'b0);
        check_value("rx word count", rx_words.size() - base, 0);

        // 9 words into 8 entries with the rx channel stalled
        write_reg(REG_CTRL, CTRL_TX | CTRL_RX);
        data_rx_ready <= 1'b0;
        base = rx_words.size();
        for (int r = 0; r < 3; r++)
            send_frame(2, 1'b0);   // status reads here would clear the flag
        read_reg(REG_STATUS, rd);
        check_value("cfg_data_o rx ovf", rd[STATUS_RX_OVF_BIT], 1'b1);
        read_reg(REG_STATUS, rd);
        check_value("cfg_data_o rx ovf", rd[STATUS_RX_OVF_BIT], 1'b0);
        data_rx_ready <= 1'b1;
        n = 0;
        while (data_rx_valid) begin
            if (n == WAIT_LIMIT) report_timeout("rx fifo to drain");
            @(posedge sys_clk);
            n++;
        end
        check_value("rx word count", rx_words.size() - base, RX_FIFO_DEPTH);
        for (int k = 0; k < RX_FIFO_DEPTH; k++)
            check_value("data_rx_o", rx_words[base + k], frame_word[2][k % 3]);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
source/eth_pkg.sv
source/eth_regs.sv
source/eth_tx_fetch.sv
source/eth_rmii_tx.sv
source/eth_rmii_rx.sv
source/eth_rx_pack.sv
source/eth_rx_fifo.sv
source/eth_mac_top.sv
tb/tb_eth_mac.sv

// ==== Bender.yml ====
package:
  name: eth_mac

sources:
  - source/eth_pkg.sv
  - source/eth_regs.sv
  - source/eth_tx_fetch.sv
  - source/eth_rmii_tx.sv
  - source/eth_rmii_rx.sv
  - source/eth_rx_pack.sv
  - source/eth_rx_fifo.sv
  - source/eth_mac_top.sv
  - target: test
    files:
      - tb/tb_eth_mac.sv
